// File: design/mem_defines.svh
// ======================================================================
// widths, counts and I/O region bits of the memory controller
// ======================================================================
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

`define MEM_ADDR_W      32
`define MEM_WORD_W      32
`define MEM_BYTE_W      8
`define MEM_CNT_W       2   // byte index within one access

// address bits 17:16 both set select the I/O region
`define MEM_IO_HI       17
`define MEM_IO_LO       16

`define MEM_FETCH_BYTES 4

`endif

// File: design/mem_pkg.sv
// ======================================================================
// memory controller types: vectors, request and bus structs, enums
// ======================================================================
`include "mem_defines.svh"

package mem_pkg;

  typedef logic [`MEM_ADDR_W-1:0] addr_t;
  typedef logic [`MEM_WORD_W-1:0] word_t;
  typedef logic [`MEM_BYTE_W-1:0] byte_t;
  typedef logic [`MEM_CNT_W-1:0]  cnt_t;
  typedef logic [`MEM_CNT_W-1:0]  size_t;   // bytes minus one

  typedef struct packed {
    addr_t addr;
    size_t size;
    word_t wdata;   // unused for reads
  } mem_req_t;

  typedef struct packed {
    addr_t a;
    byte_t dout;
    logic  wr;      // 1 for write
  } mem_bus_t;

  typedef enum logic [1:0] {
    CLIENT_FETCH,
    CLIENT_LOAD,
    CLIENT_STORE
  } client_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ACCESS,
    ARB_DRAIN,
    ARB_DONE
  } arb_state_t;

endpackage

// File: design/mem_arbiter_fsm.sv
// ======================================================================
// port arbiter FSM: fixed priority pick, byte stepping, grant and done
// ======================================================================
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_arbiter_fsm import mem_pkg::*; (
  input  logic    clk_in,
  input  logic    rst_in,
  input  logic    rdy_in,
  input  logic    fetch_req,
  input  logic    load_req,
  input  logic    store_req,
  input  logic    hold,
  input  logic    last,
  output logic    fetch_gnt,
  output logic    load_gnt,
  output logic    store_gnt,
  output logic    fetch_done,
  output logic    load_done,
  output logic    store_done,
  output client_t owner,
  output logic    start,
  output logic    step
);

  arb_state_t state, state_next;
  client_t    owner_q, pick;
  logic [2:0] gnt_q, done_q;   // one bit per client
  logic       go_done;

  function automatic logic [2:0] client_bit(client_t c);
    return 3'b001 << c;
  endfunction

  // store beats load beats fetch
  always_comb
  begin
    if (store_req)
      pick = CLIENT_STORE;
    else if (load_req)
      pick = CLIENT_LOAD;
    else
      pick = CLIENT_FETCH;
  end

  assign owner = (state == ARB_IDLE) ? pick : owner_q;
  assign start = (state == ARB_IDLE) && rdy_in && (fetch_req || load_req || store_req);
  assign step  = (state == ARB_ACCESS) && rdy_in && !hold;

  always_comb
  begin
    state_next = state;
    go_done    = 1'b0;
    case (state)
      ARB_IDLE:   if (start) state_next = ARB_ACCESS;
      ARB_ACCESS:
        if (step && last)
        begin
          if (owner_q == CLIENT_STORE)
          begin
            state_next = ARB_DONE;   // writes need no drain
            go_done    = 1'b1;
          end
          else
            state_next = ARB_DRAIN;  // last read byte still in flight
        end
      ARB_DRAIN:
      begin
        state_next = ARB_DONE;
        go_done    = rdy_in;
      end
      default:    state_next = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      state   <= ARB_IDLE;
      owner_q <= CLIENT_FETCH;
      gnt_q   <= '0;
      done_q  <= '0;
    end
    else
    begin
      gnt_q  <= start ? client_bit(pick) : 3'b000;     // single cycle pulses
      done_q <= go_done ? client_bit(owner_q) : 3'b000;
      if (rdy_in)
      begin
        state <= state_next;
        if (start)
          owner_q <= pick;
      end
    end
  end

  assign fetch_gnt  = gnt_q[CLIENT_FETCH];
  assign load_gnt   = gnt_q[CLIENT_LOAD];
  assign store_gnt  = gnt_q[CLIENT_STORE];
  assign fetch_done = done_q[CLIENT_FETCH];
  assign load_done  = done_q[CLIENT_LOAD];
  assign store_done = done_q[CLIENT_STORE];

endmodule

// File: design/byte_counter.sv
// ======================================================================
// byte cycle counter with last-byte flag
// ======================================================================
`timescale 1ns/1ns
`include "mem_defines.svh"

module byte_counter import mem_pkg::*; (
  input  logic  clk_in,
  input  logic  rst_in,
  input  logic  rdy_in,
  input  logic  start,
  input  logic  step,
  input  size_t size,
  output cnt_t  index,
  output logic  last
);

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
      index <= '0;
    else if (rdy_in)
    begin
      if (start)
        index <= '0;
      else if (step)
        index <= index + 1'b1;
    end
  end

  // size already holds length minus one
  assign last = (index == size);

endmodule

// File: design/byte_sequencer.sv
// ======================================================================
// request latch, byte address and write data, read assembly, I/O hold
// ======================================================================
`timescale 1ns/1ns
`include "mem_defines.svh"

module byte_sequencer import mem_pkg::*; (
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     rdy_in,
  input  logic     start,
  input  logic     step,
  input  client_t  owner,
  input  addr_t    fetch_addr,
  input  mem_req_t load_cmd,
  input  mem_req_t store_cmd,
  input  cnt_t     index,
  input  logic     io_buffer_full,
  input  byte_t    mem_din,
  output mem_bus_t mem_bus,
  output size_t    size,
  output logic     hold,
  output word_t    rdata
);

  localparam size_t FETCH_SIZE = size_t'(`MEM_FETCH_BYTES - 1);

  mem_req_t req_q;
  addr_t    byte_addr;
  logic     is_store;
  logic     io_addr;
  logic     rd_pend;   // read byte due on mem_din
  cnt_t     lane_q;

  always_ff @(posedge clk_in)
  begin
    if (rdy_in && start)
    begin
      case (owner)
        CLIENT_STORE: req_q <= store_cmd;
        CLIENT_LOAD:  req_q <= load_cmd;
        default:      req_q <= '{addr: fetch_addr, size: FETCH_SIZE, wdata: '0};
      endcase
    end
  end

  assign size      = req_q.size;
  assign byte_addr = req_q.addr + addr_t'(index);
  assign is_store  = (owner == CLIENT_STORE);
  assign io_addr   = byte_addr[`MEM_IO_HI] && byte_addr[`MEM_IO_LO];

  // uart side full, hold the byte until it drains
  assign hold = is_store && io_addr && io_buffer_full;

  assign mem_bus.a    = byte_addr;
  assign mem_bus.dout = req_q.wdata[index*`MEM_BYTE_W +: `MEM_BYTE_W];
  assign mem_bus.wr   = step && is_store;   // step is low while rdy_in is low

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      rd_pend <= 1'b0;
      lane_q  <= '0;
    end
    else
    begin
      rd_pend <= step && !is_store;
      lane_q  <= index;
    end
  end

  // memory answers one cycle after the address even when paused
  always_ff @(posedge clk_in)
  begin
    if (rdy_in && start)
      rdata <= '0;   // short loads come back zero extended
    else if (rd_pend)
      rdata[lane_q*`MEM_BYTE_W +: `MEM_BYTE_W] <= mem_din;
  end

endmodule

// File: design/mem_ctrl.sv
// ======================================================================
// memory controller top: fetch, load and store share one byte port
// ======================================================================
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_ctrl import mem_pkg::*; (
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     rdy_in,

  input  logic     fetch_req,
  input  addr_t    fetch_addr,
  output logic     fetch_gnt,
  output logic     fetch_done,
  output word_t    fetch_data,

  input  logic     load_req,
  input  mem_req_t load_cmd,
  output logic     load_gnt,
  output logic     load_done,
  output word_t    load_data,

  input  logic     store_req,
  input  mem_req_t store_cmd,
  output logic     store_gnt,
  output logic     store_done,

  input  byte_t    mem_din,
  output mem_bus_t mem_bus,
  input  logic     io_buffer_full
);

  client_t owner;
  logic    start, step, hold, last;
  cnt_t    index;
  size_t   size;
  word_t   rdata;

  mem_arbiter_fsm i_arbiter (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_in     (rdy_in),
    .fetch_req  (fetch_req),
    .load_req   (load_req),
    .store_req  (store_req),
    .hold       (hold),
    .last       (last),
    .fetch_gnt  (fetch_gnt),
    .load_gnt   (load_gnt),
    .store_gnt  (store_gnt),
    .fetch_done (fetch_done),
    .load_done  (load_done),
    .store_done (store_done),
    .owner      (owner),
    .start      (start),
    .step       (step)
  );

  byte_counter i_counter (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .rdy_in (rdy_in),
    .start  (start),
    .step   (step),
    .size   (size),
    .index  (index),
    .last   (last)
  );

  byte_sequencer i_sequencer (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .start          (start),
    .step           (step),
    .owner          (owner),
    .fetch_addr     (fetch_addr),
    .load_cmd       (load_cmd),
    .store_cmd      (store_cmd),
    .index          (index),
    .io_buffer_full (io_buffer_full),
    .mem_din        (mem_din),
    .mem_bus        (mem_bus),
    .size           (size),
    .hold           (hold),
    .rdata          (rdata)
  );

  // only one read owns the port, so both clients see the same word
  assign fetch_data = rdata;
  assign load_data  = rdata;

endmodule

// File: bench/mem_ctrl_tasks.svh
// ======================================================================
// directed tests: reset, fetch, loads, stores, priority, pause, I/O hold
// ======================================================================

task automatic check_reset_state();
  int err_start;
  err_start = errors;
  expect_eq("grant, done and wr after reset",
            {fetch_gnt, load_gnt, store_gnt, fetch_done, load_done, store_done, mem_bus.wr},
            '0);
  print_result("reset", err_start);
endtask

task automatic fetch_aligned_word();
  int    err_start;
  addr_t addr;
  word_t data;
  time   t_gnt;
  err_start = errors;
  addr      = $urandom & 32'h0000_fffc;
  fetch_word(addr, data, t_gnt);
  expect_eq("fetch data", data, model_word(addr, 2'd3));
  expect_eq("fetch cycles from gnt to done", 32'(($time - t_gnt) / CLK_PERIOD), 5);
  print_result("fetch", err_start);
endtask

task automatic load_sizes();
  size_t sizes [3] = '{2'd0, 2'd1, 2'd3};
  int    err_start;
  addr_t addr;
  word_t data;
  time   t_gnt;
  err_start = errors;
  foreach (sizes[i])
  begin
    addr = $urandom & 32'h0000_7ff7;
    load_bytes(addr, sizes[i], data, t_gnt);
    expect_eq($sformatf("load of %0d bytes", sizes[i] + 1), data, model_word(addr, sizes[i]));
  end
  print_result("loads", err_start);
endtask

task automatic store_and_read_back();
  size_t sizes [3] = '{2'd0, 2'd1, 2'd3};
  int    err_start;
  addr_t addr;
  word_t wdata, mask, old, data;
  time   t_gnt;
  err_start = errors;
  foreach (sizes[i])
  begin
    addr  = 32'h0000_8000 + ($urandom & 32'h0000_3ff7);
    wdata = $urandom;
    mask  = 32'hffff_ffff >> (8 * (3 - sizes[i]));
    old   = model_word(addr, 2'd3);   // neighbours must survive
    store_bytes(addr, sizes[i], wdata, t_gnt);
    expect_eq("memory after store", model_word(addr, 2'd3), (wdata & mask) | (old & ~mask));
    load_bytes(addr, sizes[i], data, t_gnt);
    expect_eq("load after store", data, wdata & mask);
  end
  print_result("stores", err_start);
endtask

task automatic priority_order();
  int    err_start;
  addr_t a;
  word_t wd, ld, fd, exp_ld, exp_fd;
  time   ts, tl, tf;
  err_start = errors;
  a         = $urandom & 32'h0000_3ffc;
  wd        = $urandom;
  exp_ld    = model_word(a + 32'h4000, 2'd3);
  exp_fd    = model_word(a + 32'h8000, 2'd3);
  fork
    store_bytes(a, 2'd3, wd, ts);
    load_bytes(a + 32'h4000, 2'd3, ld, tl);
    fetch_word(a + 32'h8000, fd, tf);
  join
  expect_eq("store granted before load", ts < tl, 1);
  expect_eq("load granted before fetch", tl < tf, 1);
  expect_eq("stored word", model_word(a, 2'd3), wd);
  expect_eq("load data", ld, exp_ld);
  expect_eq("fetch data", fd, exp_fd);
  print_result("priority", err_start);
endtask

// random rdy_in low cycles across a store followed by a load
task automatic pause_during_access();
  int    err_start;
  addr_t la;
  word_t wd, ld, exp_ld;
  time   tl, ts;
  err_start = errors;
  la        = $urandom & 32'h0000_3ffc;
  wd        = $urandom;
  exp_ld    = model_word(la, 2'd3);
  fork
    load_bytes(la, 2'd3, ld, tl);
    store_bytes(la + 32'h4000, 2'd3, wd, ts);
    begin
      repeat (24)
      begin
        @(negedge clk_in);
        expect_eq("mem_bus.wr while rdy_in low", rdy_in || !mem_bus.wr, 1);
        rdy_in = ($urandom % 3) != 0;
      end
      rdy_in = 1'b1;
    end
  join
  expect_eq("load data with pauses", ld, exp_ld);
  expect_eq("stored word with pauses", model_word(la + 32'h4000, 2'd3), wd);
  print_result("pause", err_start);
endtask

task automatic io_hold_store();
  int    err_start;
  byte_t wb;
  time   t_gnt, t_free;
  err_start      = errors;
  wb             = byte_t'($urandom);
  io_buffer_full = 1'b1;
  io_q.delete();
  fork
    store_bytes(32'h0003_0000, 2'd0, word_t'(wb), t_gnt);
    begin
      repeat (6)
        @(negedge clk_in);
      expect_eq("I/O writes while buffer full", io_q.size(), 0);
      t_free         = $time;
      io_buffer_full = 1'b0;
    end
  join
  expect_eq("store done after full dropped", $time > t_free, 1);
  expect_eq("I/O write count", io_q.size(), 1);
  if (io_q.size() == 1)
    expect_eq("I/O byte", io_q[0], wb);
  print_result("io hold", err_start);
endtask

// File: bench/mem_ctrl_tb.sv
// ======================================================================
// testbench for mem_ctrl: clock, reset, byte memory model, timeout
// ======================================================================
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_ctrl_tb import mem_pkg::*; ();

  localparam time         CLK_PERIOD     = 40;
  localparam int          TIMEOUT_CYCLES = 4000;   // all tests need under 200 cycles
  localparam int unsigned RAND_SEED      = 32'h0bcb_c1f2;

  logic     clk_in, rst_in, rdy_in;
  logic     fetch_req, load_req, store_req;
  addr_t    fetch_addr;
  mem_req_t load_cmd, store_cmd;
  logic     fetch_gnt, fetch_done, load_gnt, load_done, store_gnt, store_done;
  word_t    fetch_data, load_data;
  byte_t    mem_din = '0;
  mem_bus_t mem_bus;
  logic     io_buffer_full;

  byte_t       mem [0:65535];
  byte_t       io_q [$];   // bytes written to the I/O region
  int          errors = 0;
  int          tests  = 0;
  int          cycles = 0;
  int unsigned seed_ret;

  mem_ctrl i_mem_ctrl (.*);

  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  // byte memory, read data one cycle after the address
  always @(posedge clk_in)
  begin
    mem_din <= mem[mem_bus.a[15:0]];
    if (mem_bus.wr)
    begin
      if (mem_bus.a[`MEM_IO_HI] && mem_bus.a[`MEM_IO_LO])
        io_q.push_back(mem_bus.dout);
      else
        mem[mem_bus.a[15:0]] <= mem_bus.dout;
    end
  end

  always @(posedge clk_in)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // little endian bytes of the model, upper lanes zero
  function automatic word_t model_word(input addr_t addr, input size_t size);
    word_t w;
    w = '0;
    for (int i = 0; i <= int'(size); i++)
      w[i*8 +: 8] = mem[16'(addr + addr_t'(i))];
    return w;
  endfunction

  task automatic print_result(input string name, input int err_start);
    tests++;
    if (errors == err_start)
      $display("%-8s passed", name);
    else
      $display("%-8s FAILED with %0d mismatches", name, errors - err_start);
  endtask

  task automatic fetch_word(input addr_t addr, output word_t data, output time t_gnt);
    fetch_addr = addr;
    fetch_req  = 1'b1;
    @(negedge clk_in);
    while (!fetch_gnt)
      @(negedge clk_in);
    t_gnt     = $time;
    fetch_req = 1'b0;
    while (!fetch_done)
      @(negedge clk_in);
    data = fetch_data;
  endtask

  task automatic load_bytes(input addr_t addr, input size_t size, output word_t data,
                            output time t_gnt);
    load_cmd = '{addr: addr, size: size, wdata: '0};
    load_req = 1'b1;
    @(negedge clk_in);
    while (!load_gnt)
      @(negedge clk_in);
    t_gnt    = $time;
    load_req = 1'b0;
    while (!load_done)
      @(negedge clk_in);
    data = load_data;
  endtask

  task automatic store_bytes(input addr_t addr, input size_t size, input word_t wdata,
                             output time t_gnt);
    store_cmd = '{addr: addr, size: size, wdata: wdata};
    store_req = 1'b1;
    @(negedge clk_in);
    while (!store_gnt)
      @(negedge clk_in);
    t_gnt     = $time;
    store_req = 1'b0;
    while (!store_done)
      @(negedge clk_in);
  endtask

  `include "mem_ctrl_tasks.svh"

  initial
  begin
    seed_ret       = $urandom(RAND_SEED);
    clk_in         = 1'b0;
    rst_in         = 1'b1;
    rdy_in         = 1'b1;
    fetch_req      = 1'b0;
    load_req       = 1'b0;
    store_req      = 1'b0;
    fetch_addr     = '0;
    load_cmd       = '0;
    store_cmd      = '0;
    io_buffer_full = 1'b0;
    for (int i = 0; i < 65536; i++)
      mem[i] = byte_t'(i ^ (i >> 8) ^ 8'h5a);
    repeat (10)
      @(negedge clk_in);
    rst_in = 1'b0;

    check_reset_state();
    fetch_aligned_word();
    load_sizes();
    store_and_read_back();
    priority_order();
    pause_during_access();
    io_hold_store();

    $display("%0d tests run, %0d mismatches", tests, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: sim.f
+incdir+design
+incdir+bench
design/mem_pkg.sv
design/mem_arbiter_fsm.sv
design/byte_counter.sv
design/byte_sequencer.sv
design/mem_ctrl.sv
bench/mem_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the memory controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module mem_ctrl_tb -o mem_ctrl_sim

./obj_dir/mem_ctrl_sim | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
